// File: src/host_stream_pkg.sv
// ====================================================================
// Host stream definitions shared by the shim, the command decoder,
// the status sender and the testbench. Holds the beat widths, the
// message opcodes and the bit positions of every message field.
// ====================================================================
`default_nettype none

package host_stream_pkg;

  localparam int HOST_DATA_W = 64;
  localparam int HOST_KEEP_W = 8;

  typedef logic [HOST_DATA_W-1:0] host_data_t;
  typedef logic [HOST_KEEP_W-1:0] host_keep_t;

  localparam int OPC_W = 8;
  localparam logic [OPC_W-1:0] OPC_START  = 8'h01;
  localparam logic [OPC_W-1:0] OPC_STATUS = 8'h81;

  // Command beat fields
  localparam int CMD_OPC_LSB  = 0;
  localparam int CMD_CNT_LSB  = 8;
  localparam int CMD_ADDR_LSB = 16;
  localparam int CMD_SEED_LSB = 32;

  // Status beat 0 fields
  localparam int ST_OPC_LSB  = 0;
  localparam int ST_CNT_LSB  = 8;
  localparam int ST_ERR_LSB  = 16;
  localparam int ST_SEED_LSB = 32;

  // Status beat 1 fields, zero when the run was clean
  localparam int ST_FADDR_LSB = 0;
  localparam int ST_FDATA_LSB = 32;

endpackage

`default_nettype wire

// File: src/mem_tg_pkg.sv
// ====================================================================
// Memory side definitions for the traffic generator: address, data,
// word and error count types, the pattern step between words and the
// generator state encoding.
// ====================================================================
`default_nettype none

package mem_tg_pkg;

  localparam int MEM_ADDR_W = 16;
  localparam int MEM_DATA_W = 32;
  localparam int WORD_CNT_W = 8;
  localparam int ERR_CNT_W  = 16;

  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [MEM_DATA_W-1:0] mem_data_t;
  typedef logic [WORD_CNT_W-1:0] word_cnt_t;
  typedef logic [ERR_CNT_W-1:0]  err_cnt_t;

  // Word i of a run is seed + i * PATTERN_STEP, wrapping at 32 bits
  localparam mem_data_t PATTERN_STEP = 32'h01010101;

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    READ,
    DONE
  } tg_state_t;

endpackage

`default_nettype wire

// File: src/host_chan_shim.sv
// ====================================================================
// Platform shim between the host channel streams and the generator.
// Maps both streams by wire, adds start and end of packet flags toward
// the host and tracks start of packet on the receive side.
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module host_chan_shim
  import host_stream_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  // Host receive stream
  input  wire        host_rx_valid,
  output logic       host_rx_ready,
  input  host_data_t host_rx_data,
  input  host_keep_t host_rx_keep,
  input  wire        host_rx_last,
  input  wire        host_rx_dm_mode,
  // Host transmit stream
  output logic       host_tx_valid,
  input  wire        host_tx_ready,
  output host_data_t host_tx_data,
  output host_keep_t host_tx_keep,
  output logic       host_tx_last,
  output logic       host_tx_sop,
  output logic       host_tx_eop,
  output logic       host_tx_dm_mode,
  // Generator side receive stream
  output logic       rx_valid,
  input  wire        rx_ready,
  output host_data_t rx_data,
  output host_keep_t rx_keep,
  output logic       rx_last,
  output logic       rx_sop,
  output logic       rx_dm_mode,
  // Generator side transmit stream
  input  wire        tx_valid,
  output logic       tx_ready,
  input  host_data_t tx_data,
  input  host_keep_t tx_keep,
  input  wire        tx_last,
  input  wire        tx_dm_mode
);

  logic tx_sop;

  // Receive direction
  assign host_rx_ready = rx_ready;
  assign rx_valid      = host_rx_valid;
  assign rx_data       = host_rx_data;
  assign rx_keep       = host_rx_keep;
  assign rx_last       = host_rx_last;
  assign rx_dm_mode    = host_rx_dm_mode;

  // Transmit direction, eop is simply the last flag
  assign tx_ready        = host_tx_ready;
  assign host_tx_valid   = tx_valid;
  assign host_tx_data    = tx_data;
  assign host_tx_keep    = tx_keep;
  assign host_tx_last    = tx_last;
  assign host_tx_eop     = tx_last;
  assign host_tx_sop     = tx_sop;
  assign host_tx_dm_mode = tx_dm_mode;

  // Next beat starts a packet when the previous one ended it
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      tx_sop <= 1'b1;
      rx_sop <= 1'b1;
    end
    else
    begin
      if (tx_valid && host_tx_ready)
        tx_sop <= tx_last;
      if (host_rx_valid && rx_ready)
        rx_sop <= host_rx_last;
    end
  end

endmodule

`default_nettype wire

// File: src/tg_cmd_decoder.sv
// ====================================================================
// Command decoder for the receive stream. Single-beat start commands
// become a one-cycle start pulse with their fields held alongside;
// all other beats are consumed and dropped.
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module tg_cmd_decoder
  import host_stream_pkg::*;
  import mem_tg_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rx_valid,
  output logic       rx_ready,
  input  host_data_t rx_data,
  input  wire        rx_last,
  input  wire        rx_sop,
  input  wire        rx_dm_mode,
  input  wire        tg_active,
  output logic       start,
  output word_cnt_t  cmd_count,
  output mem_addr_t  cmd_addr,
  output mem_data_t  cmd_seed,
  output logic       cmd_dm_mode
);

  logic rx_fire;
  logic is_start;

  // Also stall during the start cycle, before tg_active has risen
  assign rx_ready = !(tg_active || start);
  assign rx_fire  = rx_valid && rx_ready;
  assign is_start = rx_sop && rx_last && (rx_data[CMD_OPC_LSB +: OPC_W] == OPC_START);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      start <= 1'b0;
    else
      start <= rx_fire && is_start;
  end

  // Command fields
  always_ff @(posedge clk)
  begin
    if (rx_fire && is_start)
    begin
      cmd_count   <= rx_data[CMD_CNT_LSB +: WORD_CNT_W];
      cmd_addr    <= rx_data[CMD_ADDR_LSB +: MEM_ADDR_W];
      cmd_seed    <= rx_data[CMD_SEED_LSB +: MEM_DATA_W];
      cmd_dm_mode <= rx_dm_mode;
    end
  end

endmodule

`default_nettype wire

// File: src/mem_traffic_gen.sv
// ====================================================================
// Write, read-back and compare engine for one memory bank. Writes the
// pattern run, issues the reads with several in flight and checks each
// response against the expected word, recording the first mismatch.
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module mem_traffic_gen
  import mem_tg_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  wire       start,
  input  word_cnt_t cmd_count,
  input  mem_addr_t cmd_addr,
  input  mem_data_t cmd_seed,
  // Write request
  output logic      mem_wr_valid,
  input  wire       mem_wr_ready,
  output mem_addr_t mem_wr_addr,
  output mem_data_t mem_wr_data,
  // Read request
  output logic      mem_rd_valid,
  input  wire       mem_rd_ready,
  output mem_addr_t mem_rd_addr,
  // Read response, always accepted
  input  wire       mem_rsp_valid,
  input  mem_data_t mem_rsp_data,
  // Results
  output logic      done,
  output err_cnt_t  err_count,
  output mem_addr_t first_err_addr,
  output mem_data_t first_err_data
);

  tg_state_t state;
  word_cnt_t cnt_q;
  mem_addr_t base_q;
  word_cnt_t req_idx;
  word_cnt_t rsp_idx;
  mem_data_t exp_data;
  logic      req_last;

  assign req_last = (req_idx == cnt_q - word_cnt_t'(1));

  // ==================================================================
  // Request FSM
  // ==================================================================
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state        <= IDLE;
      mem_wr_valid <= 1'b0;
      mem_rd_valid <= 1'b0;
      done         <= 1'b0;
      req_idx      <= '0;
    end
    else
    begin
      done <= 1'b0;
      unique case (state)
        IDLE:
          if (start)
          begin
            req_idx      <= '0;
            mem_wr_valid <= (cmd_count != '0);
            state        <= (cmd_count == '0) ? DONE : WRITE;
          end
        WRITE:
          if (mem_wr_ready)
          begin
            if (req_last)
            begin
              mem_wr_valid <= 1'b0;
              mem_rd_valid <= 1'b1;
              req_idx      <= '0;
              state        <= READ;
            end
            else
              req_idx <= req_idx + word_cnt_t'(1);
          end
        READ:
          if (mem_rd_ready)
          begin
            if (req_last)
            begin
              mem_rd_valid <= 1'b0;
              state        <= DONE;
            end
            else
              req_idx <= req_idx + word_cnt_t'(1);
          end
        DONE:
          // Wait for the last outstanding response
          if (rsp_idx == cnt_q)
          begin
            done  <= 1'b1;
            state <= IDLE;
          end
        default:
          state <= IDLE;
      endcase
    end
  end

  // Request payload, stepped on each transfer
  always_ff @(posedge clk)
  begin
    if (state == IDLE && start)
    begin
      cnt_q       <= cmd_count;
      base_q      <= cmd_addr;
      mem_wr_addr <= cmd_addr;
      mem_wr_data <= cmd_seed;
    end
    if (mem_wr_valid && mem_wr_ready)
    begin
      mem_wr_addr <= mem_wr_addr + mem_addr_t'(1);
      mem_wr_data <= mem_wr_data + PATTERN_STEP;
    end
    if (state == WRITE && mem_wr_ready && req_last)
      mem_rd_addr <= base_q;
    else if (mem_rd_valid && mem_rd_ready)
      mem_rd_addr <= mem_rd_addr + mem_addr_t'(1);
  end

  // ==================================================================
  // Response checker
  // ==================================================================
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      rsp_idx   <= '0;
      err_count <= '0;
    end
    else if (state == IDLE && start)
    begin
      rsp_idx   <= '0;
      err_count <= '0;
    end
    else if (mem_rsp_valid)
    begin
      rsp_idx <= rsp_idx + word_cnt_t'(1);
      if (mem_rsp_data != exp_data)
        err_count <= err_count + err_cnt_t'(1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == IDLE && start)
    begin
      exp_data       <= cmd_seed;
      first_err_addr <= '0;
      first_err_data <= '0;
    end
    else if (mem_rsp_valid)
    begin
      exp_data <= exp_data + PATTERN_STEP;
      // Only the first mismatch of a run is kept
      if (mem_rsp_data != exp_data && err_count == '0)
      begin
        first_err_addr <= base_q + mem_addr_t'(rsp_idx);
        first_err_data <= mem_rsp_data;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/tg_status_tx.sv
// ====================================================================
// Status sender. Tracks test activity from start to the end of the
// status message and sends the two-beat result on the transmit
// stream, holding each beat while the host stalls.
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module tg_status_tx
  import host_stream_pkg::*;
  import mem_tg_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        start,
  input  word_cnt_t  cmd_count,
  input  mem_data_t  cmd_seed,
  input  wire        cmd_dm_mode,
  input  wire        done,
  input  err_cnt_t   err_count,
  input  mem_addr_t  first_err_addr,
  input  mem_data_t  first_err_data,
  output logic       tx_valid,
  input  wire        tx_ready,
  output host_data_t tx_data,
  output host_keep_t tx_keep,
  output logic       tx_last,
  output logic       tx_dm_mode,
  output logic       tg_active
);

  logic      beat_sel;
  word_cnt_t cnt_q;
  mem_data_t seed_q;
  err_cnt_t  err_q;
  mem_addr_t faddr_q;
  mem_data_t fdata_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      tg_active <= 1'b0;
      tx_valid  <= 1'b0;
      beat_sel  <= 1'b0;
    end
    else
    begin
      if (start)
        tg_active <= 1'b1;
      if (done)
      begin
        tx_valid <= 1'b1;
        beat_sel <= 1'b0;
      end
      else if (tx_valid && tx_ready)
      begin
        beat_sel <= !beat_sel;
        // Final beat ends the test
        if (beat_sel)
        begin
          tx_valid  <= 1'b0;
          tg_active <= 1'b0;
        end
      end
    end
  end

  // Command fields at start, results at done
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      cnt_q      <= cmd_count;
      seed_q     <= cmd_seed;
      tx_dm_mode <= cmd_dm_mode;
    end
    if (done)
    begin
      err_q   <= err_count;
      faddr_q <= first_err_addr;
      fdata_q <= first_err_data;
    end
  end

  always_comb
  begin
    tx_data = '0;
    if (!beat_sel)
    begin
      tx_data[ST_OPC_LSB +: OPC_W]       = OPC_STATUS;
      tx_data[ST_CNT_LSB +: WORD_CNT_W]  = cnt_q;
      tx_data[ST_ERR_LSB +: ERR_CNT_W]   = err_q;
      tx_data[ST_SEED_LSB +: MEM_DATA_W] = seed_q;
    end
    else
    begin
      tx_data[ST_FADDR_LSB +: MEM_ADDR_W] = faddr_q;
      tx_data[ST_FDATA_LSB +: MEM_DATA_W] = fdata_q;
    end
  end

  assign tx_keep = '1;
  assign tx_last = beat_sel;

endmodule

`default_nettype wire

// File: src/mem_tg_afu.sv
// ====================================================================
// Memory traffic generator top level. Connects the host channel shim,
// command decoder, generator engine and status sender for one host
// channel and one memory bank.
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module mem_tg_afu
  import host_stream_pkg::*;
  import mem_tg_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        host_rx_valid,
  output logic       host_rx_ready,
  input  host_data_t host_rx_data,
  input  host_keep_t host_rx_keep,
  input  wire        host_rx_last,
  input  wire        host_rx_dm_mode,
  output logic       host_tx_valid,
  input  wire        host_tx_ready,
  output host_data_t host_tx_data,
  output host_keep_t host_tx_keep,
  output logic       host_tx_last,
  output logic       host_tx_sop,
  output logic       host_tx_eop,
  output logic       host_tx_dm_mode,
  output logic       mem_wr_valid,
  input  wire        mem_wr_ready,
  output mem_addr_t  mem_wr_addr,
  output mem_data_t  mem_wr_data,
  output logic       mem_rd_valid,
  input  wire        mem_rd_ready,
  output mem_addr_t  mem_rd_addr,
  input  wire        mem_rsp_valid,
  input  mem_data_t  mem_rsp_data,
  output logic       tg_active
);

  // Generator side streams
  logic       rx_valid;
  logic       rx_ready;
  host_data_t rx_data;
  logic       rx_last;
  logic       rx_sop;
  logic       rx_dm_mode;
  logic       tx_valid;
  logic       tx_ready;
  host_data_t tx_data;
  host_keep_t tx_keep;
  logic       tx_last;
  logic       tx_dm_mode;

  // Command and result handoff
  logic       start;
  word_cnt_t  cmd_count;
  mem_addr_t  cmd_addr;
  mem_data_t  cmd_seed;
  logic       cmd_dm_mode;
  logic       done;
  err_cnt_t   err_count;
  mem_addr_t  first_err_addr;
  mem_data_t  first_err_data;

  host_chan_shim u_shim (
    .clk             (clk),
    .rst_n           (rst_n),
    .host_rx_valid   (host_rx_valid),
    .host_rx_ready   (host_rx_ready),
    .host_rx_data    (host_rx_data),
    .host_rx_keep    (host_rx_keep),
    .host_rx_last    (host_rx_last),
    .host_rx_dm_mode (host_rx_dm_mode),
    .host_tx_valid   (host_tx_valid),
    .host_tx_ready   (host_tx_ready),
    .host_tx_data    (host_tx_data),
    .host_tx_keep    (host_tx_keep),
    .host_tx_last    (host_tx_last),
    .host_tx_sop     (host_tx_sop),
    .host_tx_eop     (host_tx_eop),
    .host_tx_dm_mode (host_tx_dm_mode),
    .rx_valid        (rx_valid),
    .rx_ready        (rx_ready),
    .rx_data         (rx_data),
    // Commands are whole single beats, byte enables are not needed
    .rx_keep         (),
    .rx_last         (rx_last),
    .rx_sop          (rx_sop),
    .rx_dm_mode      (rx_dm_mode),
    .tx_valid        (tx_valid),
    .tx_ready        (tx_ready),
    .tx_data         (tx_data),
    .tx_keep         (tx_keep),
    .tx_last         (tx_last),
    .tx_dm_mode      (tx_dm_mode)
  );

  tg_cmd_decoder u_decoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .rx_valid    (rx_valid),
    .rx_ready    (rx_ready),
    .rx_data     (rx_data),
    .rx_last     (rx_last),
    .rx_sop      (rx_sop),
    .rx_dm_mode  (rx_dm_mode),
    .tg_active   (tg_active),
    .start       (start),
    .cmd_count   (cmd_count),
    .cmd_addr    (cmd_addr),
    .cmd_seed    (cmd_seed),
    .cmd_dm_mode (cmd_dm_mode)
  );

  mem_traffic_gen u_gen (
    .clk            (clk),
    .rst_n          (rst_n),
    .start          (start),
    .cmd_count      (cmd_count),
    .cmd_addr       (cmd_addr),
    .cmd_seed       (cmd_seed),
    .mem_wr_valid   (mem_wr_valid),
    .mem_wr_ready   (mem_wr_ready),
    .mem_wr_addr    (mem_wr_addr),
    .mem_wr_data    (mem_wr_data),
    .mem_rd_valid   (mem_rd_valid),
    .mem_rd_ready   (mem_rd_ready),
    .mem_rd_addr    (mem_rd_addr),
    .mem_rsp_valid  (mem_rsp_valid),
    .mem_rsp_data   (mem_rsp_data),
    .done           (done),
    .err_count      (err_count),
    .first_err_addr (first_err_addr),
    .first_err_data (first_err_data)
  );

  tg_status_tx u_status (
    .clk            (clk),
    .rst_n          (rst_n),
    .start          (start),
    .cmd_count      (cmd_count),
    .cmd_seed       (cmd_seed),
    .cmd_dm_mode    (cmd_dm_mode),
    .done           (done),
    .err_count      (err_count),
    .first_err_addr (first_err_addr),
    .first_err_data (first_err_data),
    .tx_valid       (tx_valid),
    .tx_ready       (tx_ready),
    .tx_data        (tx_data),
    .tx_keep        (tx_keep),
    .tx_last        (tx_last),
    .tx_dm_mode     (tx_dm_mode),
    .tg_active      (tg_active)
  );

endmodule

`default_nettype wire

// File: testbench/mem_tg_afu_chk.sv
// ====================================================================
// Assertions bound into the traffic generator top level. Checks the
// transmit stream hold rule, reset values and start of packet.
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module mem_tg_afu_chk
  import host_stream_pkg::*;
(
  input wire        clk,
  input wire        rst_n,
  input wire        host_tx_valid,
  input wire        host_tx_ready,
  input host_data_t host_tx_data,
  input wire        host_tx_last,
  input wire        host_tx_sop,
  input wire        host_rx_ready,
  input wire        mem_wr_valid,
  input wire        mem_rd_valid,
  input wire        tg_active
);

  int fail_cnt = 0;

  // Beat held steady while the host stalls
  tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
      host_tx_valid && !host_tx_ready |=>
        host_tx_valid && $stable(host_tx_data) && $stable(host_tx_last))
    else
    begin
      $error("host_tx beat changed before its transfer");
      fail_cnt++;
    end

  reset_vals: assert property (@(posedge clk)
      !rst_n |=> !mem_wr_valid && !mem_rd_valid && !host_tx_valid && !tg_active && host_rx_ready)
    else
    begin
      $error("outputs not at their reset values");
      fail_cnt++;
    end

  // Messages are two beats, so sop marks exactly the beats without last
  sop_first_beat: assert property (@(posedge clk) disable iff (!rst_n)
      host_tx_valid |-> host_tx_sop != host_tx_last)
    else
    begin
      $error("host_tx_sop does not mark the first beat of a message");
      fail_cnt++;
    end

endmodule

bind mem_tg_afu mem_tg_afu_chk u_chk (.*);

`default_nettype wire

// File: testbench/mem_tg_afu_tb.sv
// ====================================================================
// Testbench for the memory traffic generator. Drives start commands on
// the host receive stream, models one memory bank with optional fault
// injection and checks every status message against the pattern rule.
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module mem_tg_afu_tb
  import host_stream_pkg::*;
  import mem_tg_pkg::*;
();

  localparam int        TIMEOUT_CYCLES = 20000;
  localparam mem_data_t STEP           = 32'h01010101;

  logic       clk;
  logic       rst_n;
  logic       host_rx_valid;
  logic       host_rx_ready;
  host_data_t host_rx_data;
  host_keep_t host_rx_keep;
  logic       host_rx_last;
  logic       host_rx_dm_mode;
  logic       host_tx_valid;
  logic       host_tx_ready;
  host_data_t host_tx_data;
  host_keep_t host_tx_keep;
  logic       host_tx_last;
  logic       host_tx_sop;
  logic       host_tx_eop;
  logic       host_tx_dm_mode;
  logic       mem_wr_valid;
  logic       mem_wr_ready;
  mem_addr_t  mem_wr_addr;
  mem_data_t  mem_wr_data;
  logic       mem_rd_valid;
  logic       mem_rd_ready;
  mem_addr_t  mem_rd_addr;
  logic       mem_rsp_valid;
  mem_data_t  mem_rsp_data;
  logic       tg_active;

  int         seed;
  int         errors;
  int         cycle;
  int         due;
  int         last_due;
  int         cmd_xfer_cycle;
  int         status_done_cycle;
  logic       stall_en;
  logic       fault_en;
  mem_addr_t  fault_addr;
  mem_data_t  mem [0:65535];
  mem_data_t  rsp_data_q [$];
  int         rsp_due_q [$];
  host_data_t st_beat [2];
  logic [1:0] st_sop;
  logic [1:0] st_last;
  logic [1:0] st_eop;
  logic [1:0] st_dm;
  host_keep_t st_keep [2];

  mem_tg_afu DUT (.*);

  always #2 clk = ~clk;

  // Cycle count and run limit
  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Ready signals, random only while stalls are enabled
  always @(posedge clk)
  begin
    if (stall_en)
    begin
      mem_wr_ready  <= ($random(seed) & 3) != 0;
      mem_rd_ready  <= ($random(seed) & 3) != 0;
      host_tx_ready <= ($random(seed) & 1) != 0;
    end
    else
    begin
      mem_wr_ready  <= 1'b1;
      mem_rd_ready  <= 1'b1;
      host_tx_ready <= 1'b1;
    end
  end

  // ==================================================================
  // Memory model with in-order delayed responses
  // ==================================================================
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      mem_rsp_valid <= 1'b0;
      last_due = 0;
      rsp_data_q.delete();
      rsp_due_q.delete();
    end
    else
    begin
      if (mem_wr_valid && mem_wr_ready)
      begin
        if (fault_en && mem_wr_addr == fault_addr)
          mem[mem_wr_addr] <= mem_wr_data ^ 32'h1;
        else
          mem[mem_wr_addr] <= mem_wr_data;
      end
      if (mem_rd_valid && mem_rd_ready)
      begin
        due = cycle + 1 + ($random(seed) & 3);
        if (due < last_due)
          due = last_due;
        last_due = due;
        rsp_data_q.push_back(mem[mem_rd_addr]);
        rsp_due_q.push_back(due);
      end
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle)
      begin
        mem_rsp_valid <= 1'b1;
        mem_rsp_data  <= rsp_data_q.pop_front();
        void'(rsp_due_q.pop_front());
      end
      else
        mem_rsp_valid <= 1'b0;
    end
  end

  function automatic mem_data_t pattern_word(input mem_data_t seed_v, input int i);
    return seed_v + mem_data_t'(i) * STEP;
  endfunction

  function automatic host_data_t make_cmd(input logic [7:0] opc, input word_cnt_t cnt,
                                          input mem_addr_t addr, input mem_data_t seed_v);
    return {seed_v, addr, cnt, opc};
  endfunction

  task automatic check_field(input string test, input string what,
                             input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp)
    begin
      errors++;
      $display("FAILED %s %s expected 0x%h actual 0x%h", test, what, exp, act);
    end
  endtask

  // One beat on the receive stream, held until it transfers
  task automatic send_beat(input host_data_t d, input logic last, input logic dm);
    host_rx_valid   <= 1'b1;
    host_rx_data    <= d;
    host_rx_last    <= last;
    host_rx_dm_mode <= dm;
    @(posedge clk);
    while (!host_rx_ready)
      @(posedge clk);
    cmd_xfer_cycle = cycle;
    host_rx_valid <= 1'b0;
  endtask

  task automatic recv_status();
    int n;
    n = 0;
    while (n < 2)
    begin
      @(posedge clk);
      if (host_tx_valid && host_tx_ready)
      begin
        st_beat[n] = host_tx_data;
        st_keep[n] = host_tx_keep;
        st_sop[n]  = host_tx_sop;
        st_last[n] = host_tx_last;
        st_eop[n]  = host_tx_eop;
        st_dm[n]   = host_tx_dm_mode;
        n++;
      end
    end
    status_done_cycle = cycle;
  endtask

  task automatic check_status(input string name, input word_cnt_t cnt, input mem_data_t seed_v,
                              input err_cnt_t err, input mem_addr_t faddr,
                              input mem_data_t fdata, input logic dm);
    check_field(name, "status beat 0", {seed_v, err, cnt, OPC_STATUS}, st_beat[0]);
    check_field(name, "status beat 1", {fdata, 16'h0000, faddr}, st_beat[1]);
    check_field(name, "keep", 16'hffff, {st_keep[0], st_keep[1]});
    // Flags packed as {beat 0, beat 1}
    check_field(name, "sop", 2'b10, {st_sop[0], st_sop[1]});
    check_field(name, "last", 2'b01, {st_last[0], st_last[1]});
    check_field(name, "eop", 2'b01, {st_eop[0], st_eop[1]});
    check_field(name, "dm_mode", {dm, dm}, {st_dm[0], st_dm[1]});
  endtask

  task automatic run_cmd(input string name, input word_cnt_t cnt, input mem_addr_t addr,
                         input mem_data_t seed_v, input logic dm, input err_cnt_t err,
                         input mem_addr_t faddr, input mem_data_t fdata);
    send_beat(make_cmd(OPC_START, cnt, addr, seed_v), 1'b1, dm);
    recv_status();
    check_status(name, cnt, seed_v, err, faddr, fdata, dm);
  endtask

  // ==================================================================
  // Directed tests
  // ==================================================================
  task automatic clean_run();
    run_cmd("clean_run", 8'd16, 16'h0100, 32'h12345678, 1'b0, '0, '0, '0);
    for (int i = 0; i < 16; i++)
      check_field("clean_run", $sformatf("mem[%h]", 16'h0100 + i),
                  pattern_word(32'h12345678, i), mem[16'h0100 + i]);
  endtask

  task automatic fault_injection();
    fault_addr <= 16'h0205;
    fault_en   <= 1'b1;
    run_cmd("fault_inject", 8'd32, 16'h0200, 32'ha5a50000, 1'b0, 16'd1, 16'h0205,
            pattern_word(32'ha5a50000, 5) ^ 32'h1);
    fault_en <= 1'b0;
  endtask

  task automatic stalled_run();
    stall_en <= 1'b1;
    run_cmd("stalled_run", 8'd16, 16'h0100, 32'h12345678, 1'b1, '0, '0, '0);
    stall_en <= 1'b0;
  endtask

  task automatic dropped_beats();
    logic seen;
    seen = 1'b0;
    send_beat(make_cmd(8'h02, 8'd4, 16'h0300, 32'h1), 1'b1, 1'b0);
    send_beat(make_cmd(OPC_START, 8'd4, 16'h0300, 32'h1), 1'b0, 1'b0);
    send_beat(make_cmd(OPC_START, 8'd4, 16'h0300, 32'h1), 1'b1, 1'b0);
    // Discarded beats must leave the generator idle
    repeat (50)
    begin
      @(posedge clk);
      if ((host_tx_valid || tg_active) && !seen)
      begin
        seen = 1'b1;
        errors++;
        $display("dropped_beats: a discarded beat started a test or a status message");
      end
    end
    run_cmd("after_drop", 8'd8, 16'h0400, 32'h0badf00d, 1'b0, '0, '0, '0);
  endtask

  task automatic busy_stall();
    send_beat(make_cmd(OPC_START, 8'd20, 16'h0500, 32'h55aa0000), 1'b1, 1'b0);
    fork
      recv_status();
      send_beat(make_cmd(OPC_START, 8'd0, 16'h0600, 32'hcafe0001), 1'b1, 1'b1);
    join
    check_status("busy_first", 8'd20, 32'h55aa0000, '0, '0, '0, 1'b0);
    if (cmd_xfer_cycle <= status_done_cycle)
    begin
      errors++;
      $display("busy_stall: second command was accepted before the first status ended");
    end
    recv_status();
    check_status("count_zero", 8'd0, 32'hcafe0001, '0, '0, '0, 1'b1);
  endtask

  initial
  begin
    int total;
    clk             = 1'b0;
    rst_n           = 1'b0;
    seed            = 92;
    errors          = 0;
    cycle           = 0;
    stall_en        = 1'b0;
    fault_en        = 1'b0;
    fault_addr      = '0;
    host_rx_valid   = 1'b0;
    host_rx_data    = '0;
    host_rx_keep    = '1;
    host_rx_last    = 1'b0;
    host_rx_dm_mode = 1'b0;
    host_tx_ready   = 1'b1;
    mem_wr_ready    = 1'b1;
    mem_rd_ready    = 1'b1;
    mem_rsp_valid   = 1'b0;
    mem_rsp_data    = '0;
    for (int a = 0; a < 65536; a++)
      mem[a] = (a * 32'h00010001) ^ 32'hdead0000;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    clean_run();
    fault_injection();
    stalled_run();
    dropped_beats();
    busy_stall();
    repeat (4) @(posedge clk);
    total = errors + DUT.u_chk.fail_cnt;
    $display("Errors: %0d (checks %0d, assertions %0d)", total, errors, DUT.u_chk.fail_cnt);
    if (total == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
src/host_stream_pkg.sv
src/mem_tg_pkg.sv
src/host_chan_shim.sv
src/tg_cmd_decoder.sv
src/mem_traffic_gen.sv
src/tg_status_tx.sv
src/mem_tg_afu.sv
testbench/mem_tg_afu_chk.sv
testbench/mem_tg_afu_tb.sv

// File: Bender.yml
package:
  name: mem_tg_afu

sources:
  - src/host_stream_pkg.sv
  - src/mem_tg_pkg.sv
  - src/host_chan_shim.sv
  - src/tg_cmd_decoder.sv
  - src/mem_traffic_gen.sv
  - src/tg_status_tx.sv
  - src/mem_tg_afu.sv
  - target: test
    files:
      - testbench/mem_tg_afu_chk.sv
      - testbench/mem_tg_afu_tb.sv
